/* design/sudoku_pkg.sv */
package sudoku_pkg;

	localparam int GRID_N = 9;
	localparam int DIGIT_W = 4;
	localparam int POS_W = 4;

	// cursor starts on the centre cell
	localparam logic [POS_W-1:0] CURSOR_HOME = 4'd4;

	// one board row, column 0 in the leftmost nibble
	typedef logic [0:GRID_N-1][DIGIT_W-1:0] row_t;

	// whole board, row 0 in the top 36 bits, indexed as grid[row][col]
	typedef row_t [0:GRID_N-1] grid_t;

	// starting board, 0 is an empty cell
	localparam grid_t PUZZLE = {
		36'h900020401,
		36'h005090020,
		36'h040100097,
		36'h500001000,
		36'h000000002,
		36'h400570309,
		36'h053002180,
		36'h000000000,
		36'h002800003
	};

	localparam grid_t SOLUTION = {
		36'h987625431,
		36'h315497628,
		36'h246138597,
		36'h539281746,
		36'h671349852,
		36'h428576319,
		36'h753962184,
		36'h894713265,
		36'h162854973
	};

	// active low, segment a in bit 0, g in bit 6
	localparam logic [0:GRID_N-1][6:0] SEG7_TABLE = {
		7'h40,
		7'h79,
		7'h24,
		7'h30,
		7'h19,
		7'h12,
		7'h02,
		7'h78,
		7'h00
	};

	// level inputs, digit 0 means no digit key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic erase;
		logic [DIGIT_W-1:0] digit;
	} game_keys_t;

	typedef struct packed {
		logic [POS_W-1:0] row;
		logic [POS_W-1:0] col;
	} cursor_t;

	// one-cycle pulse to the row array
	typedef struct packed {
		logic valid;
		logic erase;
		logic [POS_W-1:0] row;
		logic [POS_W-1:0] col;
		logic [DIGIT_W-1:0] digit;
	} cell_cmd_t;

	typedef struct packed {
		logic solved;
		logic [DIGIT_W-1:0] digit;
		logic wrong;
	} row_report_t;

endpackage

/* design/cursor_control.sv */
`timescale 1ns/1ps

module cursor_control (
	input logic CLOCK_50,
	input logic resetn,
	input sudoku_pkg::game_keys_t keys_i,
	input logic solved_i,
	output sudoku_pkg::cell_cmd_t cell_cmd_o,
	output sudoku_pkg::cursor_t cursor_o,
	output logic [6:0] hex_row_o,
	output logic [6:0] hex_col_o
);
	import sudoku_pkg::*;

	typedef enum logic [2:0] {
		ACT_NONE,
		ACT_DIGIT,
		ACT_ERASE,
		ACT_UP,
		ACT_DOWN,
		ACT_LEFT,
		ACT_RIGHT
	} action_t;

	localparam logic [POS_W-1:0] LAST_POS = POS_W'(GRID_N - 1);

	game_keys_t keys_q;
	game_keys_t keys_prev;
	logic press;
	action_t act_d;
	action_t act_q;
	logic [DIGIT_W-1:0] digit_q;
	cursor_t cursor_q;

	// key sampling, one action per press
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			keys_q <= '0;
			keys_prev <= '0;
		end else begin
			keys_q <= keys_i;
			keys_prev <= keys_q;
		end
	end

	assign press = (keys_q != '0) && (keys_prev == '0);

	// digit wins over erase, erase over moves
	always_comb begin
		act_d = ACT_NONE;
		if (press) begin
			if (keys_q.digit != '0)
				act_d = ACT_DIGIT;
			else if (keys_q.erase)
				act_d = ACT_ERASE;
			else if (keys_q.up)
				act_d = ACT_UP;
			else if (keys_q.down)
				act_d = ACT_DOWN;
			else if (keys_q.left)
				act_d = ACT_LEFT;
			else
				act_d = ACT_RIGHT;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn)
			act_q <= ACT_NONE;
		else
			act_q <= act_d;
	end

	always_ff @(posedge CLOCK_50) begin
		digit_q <= keys_q.digit;
	end

	// moves at the edge are dropped, nothing happens once solved
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			cursor_q.row <= CURSOR_HOME;
			cursor_q.col <= CURSOR_HOME;
			cell_cmd_o <= '0;
		end else begin
			cell_cmd_o.valid <= 1'b0;
			if (!solved_i) begin
				case (act_q)
					ACT_UP: begin
						if (cursor_q.row != '0)
							cursor_q.row <= cursor_q.row - 1'b1;
					end
					ACT_DOWN: begin
						if (cursor_q.row != LAST_POS)
							cursor_q.row <= cursor_q.row + 1'b1;
					end
					ACT_LEFT: begin
						if (cursor_q.col != '0)
							cursor_q.col <= cursor_q.col - 1'b1;
					end
					ACT_RIGHT: begin
						if (cursor_q.col != LAST_POS)
							cursor_q.col <= cursor_q.col + 1'b1;
					end
					ACT_DIGIT, ACT_ERASE: begin
						cell_cmd_o.valid <= 1'b1;
						cell_cmd_o.erase <= (act_q == ACT_ERASE);
						cell_cmd_o.row <= cursor_q.row;
						cell_cmd_o.col <= cursor_q.col;
						cell_cmd_o.digit <= (act_q == ACT_ERASE) ? '0 : digit_q;
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign cursor_o = cursor_q;
	assign hex_row_o = SEG7_TABLE[cursor_q.row];
	assign hex_col_o = SEG7_TABLE[cursor_q.col];

	cursor_in_board: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		(cursor_q.row <= LAST_POS) && (cursor_q.col <= LAST_POS));

endmodule

/* design/sudoku_row.sv */
`timescale 1ns/1ps

module sudoku_row #(
	parameter int ROW_INDEX = 0
) (
	input logic CLOCK_50,
	input logic resetn,
	input sudoku_pkg::cell_cmd_t cell_cmd_i,
	input sudoku_pkg::cursor_t cursor_i,
	output sudoku_pkg::row_report_t report_o
);
	import sudoku_pkg::*;

	localparam row_t START = PUZZLE[ROW_INDEX];
	localparam row_t ANSWER = SOLUTION[ROW_INDEX];

	row_t cells;
	logic [GRID_N-1:0] wrong;
	logic [GRID_N-1:0] given;
	row_t given_mask;
	logic hit;
	logic [POS_W-1:0] col_q;

	// cells that start non-empty are locked
	always_comb begin
		for (int c = 0; c < GRID_N; c++) begin
			given[c] = (START[c] != '0);
			given_mask[c] = {DIGIT_W{given[c]}};
		end
	end

	assign hit = cell_cmd_i.valid && (cell_cmd_i.row == POS_W'(ROW_INDEX));

	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			cells <= START;
			wrong <= '0;
		end else if (hit && !given[cell_cmd_i.col]) begin
			if (cell_cmd_i.erase) begin
				cells[cell_cmd_i.col] <= '0;
				wrong[cell_cmd_i.col] <= 1'b0;
			end else if (cells[cell_cmd_i.col] == '0) begin
				cells[cell_cmd_i.col] <= cell_cmd_i.digit;
				wrong[cell_cmd_i.col] <= (cell_cmd_i.digit != ANSWER[cell_cmd_i.col]);
			end
		end
	end

	// column view lags the cursor by one cycle, matching the row select in board_status
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn)
			col_q <= CURSOR_HOME;
		else
			col_q <= cursor_i.col;
	end

	always_comb begin
		report_o.solved = (cells == ANSWER);
		report_o.digit = cells[col_q];
		report_o.wrong = wrong[col_q];
	end

	given_cells_locked: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		$stable(cells & given_mask));

endmodule

/* design/board_status.sv */
`timescale 1ns/1ps

module board_status (
	input logic CLOCK_50,
	input logic resetn,
	input sudoku_pkg::row_report_t row_reports_i [sudoku_pkg::GRID_N],
	input sudoku_pkg::cursor_t cursor_i,
	output logic solved_o,
	output logic [sudoku_pkg::DIGIT_W-1:0] cell_digit_o,
	output logic cell_wrong_o
);
	import sudoku_pkg::*;

	logic [POS_W-1:0] row_q;
	logic all_solved;
	row_report_t sel_report;

	always_comb begin
		all_solved = 1'b1;
		for (int r = 0; r < GRID_N; r++) begin
			all_solved = all_solved & row_reports_i[r].solved;
		end
	end

	// row select follows the same one-cycle cursor lag as the rows
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn)
			row_q <= CURSOR_HOME;
		else
			row_q <= cursor_i.row;
	end

	assign sel_report = row_reports_i[row_q];

	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			cell_digit_o <= '0;
			cell_wrong_o <= 1'b0;
		end else begin
			cell_digit_o <= sel_report.digit;
			cell_wrong_o <= sel_report.wrong;
		end
	end

	// sticky until reset
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn)
			solved_o <= 1'b0;
		else if (all_solved)
			solved_o <= 1'b1;
	end

	solved_sticky: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		solved_o |=> solved_o);

endmodule

/* design/sudoku_game.sv */
`timescale 1ns/1ps

module sudoku_game (
	input logic CLOCK_50,
	input logic resetn,
	input sudoku_pkg::game_keys_t keys_i,
	output logic [6:0] hex_row_o,
	output logic [6:0] hex_col_o,
	output logic [sudoku_pkg::DIGIT_W-1:0] cell_digit_o,
	output logic cell_wrong_o,
	output logic solved_o
);
	import sudoku_pkg::*;

	cell_cmd_t cell_cmd;
	cursor_t cursor;
	row_report_t row_reports [GRID_N];

	cursor_control cursor_control_i (
		.CLOCK_50 (CLOCK_50),
		.resetn (resetn),
		.keys_i (keys_i),
		.solved_i (solved_o),
		.cell_cmd_o (cell_cmd),
		.cursor_o (cursor),
		.hex_row_o (hex_row_o),
		.hex_col_o (hex_col_o)
	);

	// one row store per board row
	for (genvar r = 0; r < GRID_N; r++) begin : g_row
		sudoku_row #(
			.ROW_INDEX (r)
		) row_i (
			.CLOCK_50 (CLOCK_50),
			.resetn (resetn),
			.cell_cmd_i (cell_cmd),
			.cursor_i (cursor),
			.report_o (row_reports[r])
		);
	end

	board_status board_status_i (
		.CLOCK_50 (CLOCK_50),
		.resetn (resetn),
		.row_reports_i (row_reports),
		.cursor_i (cursor),
		.solved_o (solved_o),
		.cell_digit_o (cell_digit_o),
		.cell_wrong_o (cell_wrong_o)
	);

endmodule

/* verification/tb_sudoku_game.sv */
`timescale 1ns/1ps

module tb_sudoku_game;
	import sudoku_pkg::*;

	localparam int CELLS = GRID_N * GRID_N;

	logic CLOCK_50;
	logic resetn;
	game_keys_t keys_i;
	logic [6:0] hex_row_o;
	logic [6:0] hex_col_o;
	logic [DIGIT_W-1:0] cell_digit_o;
	logic cell_wrong_o;
	logic solved_o;

	// expected board, marks and cursor
	logic [DIGIT_W-1:0] model_board [GRID_N][GRID_N];
	logic model_wrong [GRID_N][GRID_N];
	logic [POS_W-1:0] model_row;
	logic [POS_W-1:0] model_col;
	logic model_solved;

	logic [15:0] lfsr;
	logic [3:0] idle_cycles;
	logic check_en;
	logic [6:0] exp_hex_row;
	logic [6:0] exp_hex_col;
	logic [DIGIT_W-1:0] exp_digit;
	logic exp_wrong;

	sudoku_game dut_i (
		.CLOCK_50 (CLOCK_50),
		.resetn (resetn),
		.keys_i (keys_i),
		.hex_row_o (hex_row_o),
		.hex_col_o (hex_col_o),
		.cell_digit_o (cell_digit_o),
		.cell_wrong_o (cell_wrong_o),
		.solved_o (solved_o)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	// cycles since the keys were last released
	always @(posedge CLOCK_50) begin
		if (!resetn || keys_i != '0)
			idle_cycles <= '0;
		else if (idle_cycles != 4'hF)
			idle_cycles <= idle_cycles + 4'd1;
	end

	// outputs are settled 4 cycles after the press is sampled
	assign check_en = (keys_i == '0) && (idle_cycles >= 4'd3);
	assign exp_hex_row = SEG7_TABLE[model_row];
	assign exp_hex_col = SEG7_TABLE[model_col];
	assign exp_digit = model_board[model_row][model_col];
	assign exp_wrong = model_wrong[model_row][model_col];

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [6:0] got,
		input logic [6:0] expected);
		$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
		stop_with_failure();
	endtask

	hex_row_check: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		check_en |-> (hex_row_o == exp_hex_row))
		else report_mismatch("hex_row_o", $sampled(hex_row_o), $sampled(exp_hex_row));

	hex_col_check: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		check_en |-> (hex_col_o == exp_hex_col))
		else report_mismatch("hex_col_o", $sampled(hex_col_o), $sampled(exp_hex_col));

	digit_check: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		check_en |-> (cell_digit_o == exp_digit))
		else report_mismatch("cell_digit_o", 7'($sampled(cell_digit_o)),
			7'($sampled(exp_digit)));

	wrong_check: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		check_en |-> (cell_wrong_o == exp_wrong))
		else report_mismatch("cell_wrong_o", 7'($sampled(cell_wrong_o)),
			7'($sampled(exp_wrong)));

	solved_check: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		check_en |-> (solved_o == model_solved))
		else report_mismatch("solved_o", 7'($sampled(solved_o)), 7'($sampled(model_solved)));

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic logic is_given(input int r, input int c);
		return PUZZLE[r][c] != '0;
	endfunction

	function automatic logic board_solved();
		for (int r = 0; r < GRID_N; r++)
			for (int c = 0; c < GRID_N; c++)
				if (model_board[r][c] != SOLUTION[r][c])
					return 1'b0;
		return 1'b1;
	endfunction

	task automatic init_model();
		for (int r = 0; r < GRID_N; r++) begin
			for (int c = 0; c < GRID_N; c++) begin
				model_board[r][c] = PUZZLE[r][c];
				model_wrong[r][c] = 1'b0;
			end
		end
		model_row = CURSOR_HOME;
		model_col = CURSOR_HOME;
		model_solved = 1'b0;
	endtask

	// digit first, then erase, then up, down, left, right
	task automatic apply_to_model(input game_keys_t k);
		int r;
		int c;
		r = int'(model_row);
		c = int'(model_col);
		if (!model_solved) begin
			if (k.digit != '0) begin
				if (!is_given(r, c) && model_board[r][c] == '0) begin
					model_board[r][c] = k.digit;
					model_wrong[r][c] = (k.digit != SOLUTION[r][c]);
				end
			end else if (k.erase) begin
				if (!is_given(r, c)) begin
					model_board[r][c] = '0;
					model_wrong[r][c] = 1'b0;
				end
			end else if (k.up && r > 0)
				model_row = model_row - 4'd1;
			else if (k.down && r < GRID_N - 1)
				model_row = model_row + 4'd1;
			else if (k.left && c > 0)
				model_col = model_col - 4'd1;
			else if (k.right && c < GRID_N - 1)
				model_col = model_col + 4'd1;
			model_solved = board_solved();
		end
	endtask

	// 3 cycles held, 6 released
	task automatic press_key(input game_keys_t k);
		@(posedge CLOCK_50);
		keys_i <= k;
		// model steps while the key is seen as held
		@(posedge CLOCK_50);
		apply_to_model(k);
		repeat (2) @(posedge CLOCK_50);
		keys_i <= '0;
		repeat (5) @(posedge CLOCK_50);
	endtask

	task automatic press_dir(input int dir);
		game_keys_t k;
		k = '0;
		case (dir)
			0: k.up = 1'b1;
			1: k.down = 1'b1;
			2: k.left = 1'b1;
			default: k.right = 1'b1;
		endcase
		press_key(k);
	endtask

	task automatic press_digit(input int d);
		game_keys_t k;
		k = '0;
		k.digit = DIGIT_W'(d);
		press_key(k);
	endtask

	task automatic press_erase();
		game_keys_t k;
		k = '0;
		k.erase = 1'b1;
		press_key(k);
	endtask

	task automatic move_to(input int r, input int c);
		while (int'(model_row) > r && !model_solved)
			press_dir(0);
		while (int'(model_row) < r && !model_solved)
			press_dir(1);
		while (int'(model_col) > c && !model_solved)
			press_dir(2);
		while (int'(model_col) < c && !model_solved)
			press_dir(3);
	endtask

	// first matching cell from start on with wraparound
	function automatic int find_cell(input int start, input logic want_given);
		int idx;
		for (int i = 0; i < CELLS; i++) begin
			idx = (start + i) % CELLS;
			if (want_given && is_given(idx / GRID_N, idx % GRID_N))
				return idx;
			if (!want_given && !is_given(idx / GRID_N, idx % GRID_N)
				&& model_board[idx / GRID_N][idx % GRID_N] == '0)
				return idx;
		end
		return -1;
	endfunction

	task automatic goto_random_cell(input logic want_given);
		int v;
		int idx;
		rand_bits(7, v);
		idx = find_cell(v, want_given);
		if (idx < 0) begin
			$display("no suitable cell left on the board");
			stop_with_failure();
		end
		move_to(idx / GRID_N, idx % GRID_N);
	endtask

	function automatic int answer_here();
		return int'(SOLUTION[model_row][model_col]);
	endfunction

	task automatic fill_board();
		for (int r = 0; r < GRID_N; r++) begin
			for (int c = 0; c < GRID_N; c++) begin
				if (!is_given(r, c) && model_board[r][c] != SOLUTION[r][c]) begin
					move_to(r, c);
					if (model_board[r][c] != '0)
						press_erase();
					press_digit(int'(SOLUTION[r][c]));
				end
			end
		end
	endtask

	task automatic wait_for_solved();
		for (int i = 0; i < 20 && !solved_o; i++)
			@(posedge CLOCK_50);
		if (!solved_o) begin
			$display("timeout waiting for solved_o after the board was filled");
			stop_with_failure();
		end
	endtask

	initial begin
		int v;
		keys_i = '0;
		resetn = 1'b0;
		lfsr = 16'd29;
		init_model();
		repeat (10) @(posedge CLOCK_50);
		resetn <= 1'b1;
		repeat (8) @(posedge CLOCK_50);

		// five ups from home stop on row 0
		for (int i = 0; i < 5; i++)
			press_dir(0);
		for (int i = 0; i < 40; i++) begin
			rand_bits(2, v);
			press_dir(v);
		end
		move_to(GRID_N - 1, GRID_N - 1);
		press_dir(1);
		press_dir(3);
		move_to(0, 0);
		press_dir(0);
		press_dir(2);

		// correct entries, then overwrites that must be ignored
		for (int t = 0; t < 4; t++) begin
			goto_random_cell(1'b0);
			press_digit(answer_here());
			press_digit(answer_here() % GRID_N + 1);
		end
		goto_random_cell(1'b1);
		press_digit(answer_here() % GRID_N + 1);

		// wrong entries and erases
		for (int t = 0; t < 3; t++) begin
			goto_random_cell(1'b0);
			press_digit(answer_here() % GRID_N + 1);
			press_erase();
		end
		goto_random_cell(1'b0);
		press_digit(answer_here() % GRID_N + 1);
		goto_random_cell(1'b1);
		press_erase();

		fill_board();
		wait_for_solved();
		for (int i = 0; i < 12; i++) begin
			rand_bits(3, v);
			if (v < 4)
				press_dir(v);
			else
				press_erase();
		end
		repeat (10) @(posedge CLOCK_50);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sim.f */
design/sudoku_pkg.sv
design/cursor_control.sv
design/sudoku_row.sv
design/board_status.sv
design/sudoku_game.sv
verification/tb_sudoku_game.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_sudoku_game -o tb_sudoku_game

out=$(./obj_dir/tb_sudoku_game 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi
